// File: hdl/scope_macros.svh
`ifndef SCOPE_MACROS_SVH
`define SCOPE_MACROS_SVH

// visible framebuffer size, pixels and lines
`define FB_WIDTH 16
`define FB_HEIGHT 16

// horizontal porches and sync, in pixels
`define H_FRONT 2
`define H_SYNC 3
`define H_BACK 2
`define H_TOTAL (`FB_WIDTH + `H_FRONT + `H_SYNC + `H_BACK)

// vertical porches and sync, in lines
`define V_FRONT 1
`define V_SYNC 2
`define V_BACK 1
`define V_TOTAL (`FB_HEIGHT + `V_FRONT + `V_SYNC + `V_BACK)

// converter and colour widths
`define ADC_BITS 10
`define COLOR_BITS 4

// write queue depth, also the credit pool
`define FB_CREDITS 4
`define SETTLE_CYCLES 8

`endif

// File: hdl/scope_pkg.sv
`include "scope_macros.svh"

package scope_pkg;

  // coordinate widths follow the frame size
  localparam int X_BITS = $clog2(`FB_WIDTH);
  localparam int Y_BITS = $clog2(`FB_HEIGHT);
  localparam int PIX_BITS = 3 * `COLOR_BITS;

  // bit of REG_CTRL that kicks off a new clear
  localparam int CTRL_RESTART_BIT = 0;

  typedef struct packed {
    logic [`COLOR_BITS-1:0] red;
    logic [`COLOR_BITS-1:0] green;
    logic [`COLOR_BITS-1:0] blue;
  } rgb_t;

  // scanner read address
  typedef struct packed {
    logic [X_BITS-1:0] x;
    logic [Y_BITS-1:0] y;
  } fb_addr_t;

  // one framebuffer write
  typedef struct packed {
    logic [X_BITS-1:0]   x;
    logic [Y_BITS-1:0]   y;
    logic [PIX_BITS-1:0] color;
  } pixel_wr_t;

  typedef enum logic [1:0] {
    REG_BG_COLOR    = 2'd0,
    REG_TRACE_COLOR = 2'd1,
    REG_CTRL        = 2'd2
  } reg_addr_e;

  typedef enum logic [1:0] {
    ST_CLEAR  = 2'd0,
    ST_SETTLE = 2'd1,
    ST_TRACE  = 2'd2
  } seq_state_e;

endpackage

// File: hdl/fb_clear.sv
`timescale 1ns/10ps
`include "scope_macros.svh"

module fb_clear (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           clr_start,
  input  logic                           clr_take,
  input  logic [scope_pkg::PIX_BITS-1:0] bg_color,
  output logic                           clr_avail,
  output scope_pkg::pixel_wr_t           clr_pix,
  output logic                           clr_last
);
  import scope_pkg::*;

  // bottom right corner of the frame
  localparam logic [X_BITS-1:0] X_LAST = X_BITS'(`FB_WIDTH - 1);
  localparam logic [Y_BITS-1:0] Y_LAST = Y_BITS'(`FB_HEIGHT - 1);

  logic              active;
  logic [X_BITS-1:0] x_cnt;
  logic [Y_BITS-1:0] y_cnt;
  logic              at_end;

  assign at_end = (x_cnt == X_LAST) && (y_cnt == Y_LAST);

  // raster order sweep, one step per take
  always_ff @(posedge clk) begin
    if (rst) begin
      active <= 1'b0;
      x_cnt  <= '0;
      y_cnt  <= '0;
    end else if (clr_start) begin
      // a start mid-sweep begins again at the origin
      active <= 1'b1;
      x_cnt  <= '0;
      y_cnt  <= '0;
    end else if (clr_take && active) begin
      if (at_end) begin
        // done, idle until the next start
        active <= 1'b0;
      end else if (x_cnt == X_LAST) begin
        x_cnt <= '0;
        y_cnt <= y_cnt + 1'b1;
      end else begin
        x_cnt <= x_cnt + 1'b1;
      end
    end
  end

  // pending pixel straight from the counters
  assign clr_avail = active;
  assign clr_last  = active && at_end;

  assign clr_pix.x     = x_cnt;
  assign clr_pix.y     = y_cnt;
  // colour tracks the register, a change mid-sweep shows up at once
  assign clr_pix.color = bg_color;

endmodule

// File: hdl/adc_sampler.sv
`timescale 1ns/10ps
`include "scope_macros.svh"

module adc_sampler (
  input  logic                           clk,
  input  logic                           rst,
  input  logic [`ADC_BITS-1:0]           adc_x,
  input  logic [`ADC_BITS-1:0]           adc_y,
  input  logic                           adc_strobe,
  input  logic                           trace_take,
  input  logic [scope_pkg::PIX_BITS-1:0] trace_color,
  output logic                           trace_avail,
  output scope_pkg::pixel_wr_t           trace_pix
);
  import scope_pkg::*;

  // msb of a raw sample
  localparam int ADC_MSB = `ADC_BITS - 1;

  logic      pending;
  pixel_wr_t pend_pix;

  // pending flag, a new strobe wins over a take in the same cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      pending <= 1'b0;
    end else if (adc_strobe) begin
      pending <= 1'b1;
    end else if (trace_take) begin
      pending <= 1'b0;
    end
  end

  // newest point only, an untaken one is overwritten
  always_ff @(posedge clk) begin
    if (adc_strobe) begin
      // top bits only, so full scale spans the frame
      pend_pix.x     <= adc_x[ADC_MSB -: X_BITS];
      pend_pix.y     <= adc_y[ADC_MSB -: Y_BITS];
      // colour latched with the sample
      // later register writes leave it alone
      pend_pix.color <= trace_color;
    end
  end

  assign trace_avail = pending;
  assign trace_pix   = pend_pix;

endmodule

// File: hdl/scope_ctrl.sv
`timescale 1ns/10ps
`include "scope_macros.svh"

module scope_ctrl (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           cfg_we,
  input  scope_pkg::reg_addr_e           cfg_addr,
  input  logic [scope_pkg::PIX_BITS-1:0] cfg_wdata,
  input  logic                           clr_avail,
  input  scope_pkg::pixel_wr_t           clr_pix,
  input  logic                           clr_last,
  input  logic                           trace_avail,
  input  scope_pkg::pixel_wr_t           trace_pix,
  input  logic                           credit_ret,
  output logic [scope_pkg::PIX_BITS-1:0] bg_color,
  output logic [scope_pkg::PIX_BITS-1:0] trace_color,
  output logic                           clr_start,
  output logic                           clr_take,
  output logic                           trace_take,
  output logic                           wr_valid,
  output scope_pkg::pixel_wr_t           wr_pix
);
  import scope_pkg::*;

  localparam int CR_BITS = $clog2(`FB_CREDITS + 1);
  localparam int SETTLE_BITS = $clog2(`SETTLE_CYCLES + 1);
  localparam logic [SETTLE_BITS-1:0] SETTLE_LAST = SETTLE_BITS'(`SETTLE_CYCLES - 1);

  seq_state_e             state;
  logic [SETTLE_BITS-1:0] settle_cnt;
  logic [CR_BITS-1:0]     credits;
  logic                   has_credit;
  logic                   restart_hit;
  logic                   boot;
  logic                   trace_q;
  logic                   stale_vld;
  pixel_wr_t              stale_pix;
  logic                   trace_fresh;

  assign restart_hit = cfg_we && (cfg_addr == REG_CTRL) && cfg_wdata[CTRL_RESTART_BIT];

  // colour registers
  // clr_start doubles as the self-clearing restart bit
  always_ff @(posedge clk) begin
    if (rst) begin
      bg_color    <= '0;
      trace_color <= '1;
      clr_start   <= 1'b0;
      boot        <= 1'b1;
    end else begin
      boot      <= 1'b0;
      clr_start <= boot | restart_hit;
      if (cfg_we) begin
        case (cfg_addr)
          REG_BG_COLOR:    bg_color <= cfg_wdata;
          REG_TRACE_COLOR: trace_color <= cfg_wdata;
          default:         ;
        endcase
      end
    end
  end

  // clear, settle, trace
  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= ST_CLEAR;
      settle_cnt <= '0;
      trace_q    <= 1'b0;
    end else begin
      trace_q <= (state == ST_TRACE);
      if (restart_hit) begin
        state <= ST_CLEAR;
      end else begin
        case (state)
          ST_CLEAR: begin
            if (clr_take && clr_last) begin
              state      <= ST_SETTLE;
              settle_cnt <= '0;
            end
          end
          ST_SETTLE: begin
            if (settle_cnt == SETTLE_LAST) begin
              state <= ST_TRACE;
            end else begin
              settle_cnt <= settle_cnt + 1'b1;
            end
          end
          default: ;
        endcase
      end
    end
  end

  // remember the point held while not tracing
  // it stays blocked until a new sample replaces it
  always_ff @(posedge clk) begin
    if (rst) begin
      stale_vld <= 1'b0;
    end else if (!trace_q) begin
      stale_vld <= trace_avail;
    end else if (!trace_avail || (trace_pix != stale_pix)) begin
      stale_vld <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (!trace_q) begin
      stale_pix <= trace_pix;
    end
  end

  assign trace_fresh = trace_avail && !(stale_vld && (trace_pix == stale_pix));

  // credit pool for the framebuffer link
  always_ff @(posedge clk) begin
    if (rst) begin
      credits <= CR_BITS'(`FB_CREDITS);
    end else begin
      credits <= credits - CR_BITS'(wr_valid) + CR_BITS'(credit_ret);
    end
  end

  assign has_credit = (credits != '0);

  // take and write in the same cycle
  // no clear take while a start is still pending
  assign clr_take   = (state == ST_CLEAR) && !clr_start && clr_avail && has_credit;
  // first trace cycle still shows a point strobed earlier
  assign trace_take = (state == ST_TRACE) && trace_q && trace_fresh && has_credit;
  assign wr_valid   = clr_take || trace_take;
  assign wr_pix     = (state == ST_TRACE) ? trace_pix : clr_pix;

endmodule

// File: hdl/frame_store.sv
`timescale 1ns/10ps
`include "scope_macros.svh"

module frame_store (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           wr_valid,
  input  scope_pkg::pixel_wr_t           wr_pix,
  input  scope_pkg::fb_addr_t            rd_addr,
  output logic                           credit_ret,
  output logic [scope_pkg::PIX_BITS-1:0] rd_color
);
  import scope_pkg::*;

  localparam int DEPTH = `FB_CREDITS;
  localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_BITS = $clog2(DEPTH + 1);
  localparam int FB_WORDS = `FB_WIDTH * `FB_HEIGHT;
  localparam int ADDR_BITS = $clog2(FB_WORDS);
  localparam logic [PTR_BITS-1:0] PTR_LAST = PTR_BITS'(DEPTH - 1);

  // write queue, sized by the credit pool so it never overflows
  pixel_wr_t           q_mem [DEPTH];
  logic [PTR_BITS-1:0] wr_ptr;
  logic [PTR_BITS-1:0] rd_ptr;
  logic [CNT_BITS-1:0] q_cnt;
  logic                q_pop;
  pixel_wr_t           q_head;

  // framebuffer, one word per pixel in raster order
  logic [PIX_BITS-1:0]  fb_mem [FB_WORDS];
  logic [ADDR_BITS-1:0] wr_word;
  logic [ADDR_BITS-1:0] rd_word;

  // drain one entry every cycle the queue holds any
  assign q_pop  = (q_cnt != '0);
  assign q_head = q_mem[rd_ptr];

  assign wr_word = ADDR_BITS'(q_head.y) * ADDR_BITS'(`FB_WIDTH) + ADDR_BITS'(q_head.x);
  assign rd_word = ADDR_BITS'(rd_addr.y) * ADDR_BITS'(`FB_WIDTH) + ADDR_BITS'(rd_addr.x);

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      q_cnt      <= '0;
      credit_ret <= 1'b0;
    end else begin
      // one credit back per retired entry
      credit_ret <= q_pop;
      if (wr_valid) begin
        wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
      end
      if (q_pop) begin
        rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
      end
      q_cnt <= q_cnt + CNT_BITS'(wr_valid) - CNT_BITS'(q_pop);
    end
  end

  always_ff @(posedge clk) begin
    if (wr_valid) begin
      q_mem[wr_ptr] <= wr_pix;
    end
    if (q_pop) begin
      fb_mem[wr_word] <= q_head.color;
    end
    // scanner port, one cycle latency
    // same-address write lands a cycle later
    rd_color <= fb_mem[rd_word];
  end

endmodule

// File: hdl/vga_scan.sv
`timescale 1ns/10ps
`include "scope_macros.svh"

module vga_scan (
  input  logic                           clk,
  input  logic                           rst,
  input  logic [scope_pkg::PIX_BITS-1:0] rd_color,
  output scope_pkg::fb_addr_t            rd_addr,
  output scope_pkg::rgb_t                vga_rgb,
  output logic                           vga_hsync,
  output logic                           vga_vsync
);
  import scope_pkg::*;

  localparam int H_BITS = $clog2(`H_TOTAL);
  localparam int V_BITS = $clog2(`V_TOTAL);
  localparam logic [H_BITS-1:0] H_LAST = H_BITS'(`H_TOTAL - 1);
  localparam logic [V_BITS-1:0] V_LAST = V_BITS'(`V_TOTAL - 1);

  // sync pulses sit after the front porch
  localparam int HS_START = `FB_WIDTH + `H_FRONT;
  localparam int HS_END = HS_START + `H_SYNC;
  localparam int VS_START = `FB_HEIGHT + `V_FRONT;
  localparam int VS_END = VS_START + `V_SYNC;

  logic [H_BITS-1:0] h_cnt;
  logic [V_BITS-1:0] v_cnt;
  logic              visible;
  logic              hsync_n;
  logic              vsync_n;
  logic              vis_d;
  logic              hsync_d;
  logic              vsync_d;

  // pixel and line counters
  always_ff @(posedge clk) begin
    if (rst) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else if (h_cnt == H_LAST) begin
      h_cnt <= '0;
      v_cnt <= (v_cnt == V_LAST) ? '0 : v_cnt + 1'b1;
    end else begin
      h_cnt <= h_cnt + 1'b1;
    end
  end

  assign visible = (h_cnt < H_BITS'(`FB_WIDTH)) && (v_cnt < V_BITS'(`FB_HEIGHT));

  // active low
  assign hsync_n = !((h_cnt >= H_BITS'(HS_START)) && (h_cnt < H_BITS'(HS_END)));
  assign vsync_n = !((v_cnt >= V_BITS'(VS_START)) && (v_cnt < V_BITS'(VS_END)));

  // address parked at the origin during blanking
  assign rd_addr.x = visible ? X_BITS'(h_cnt) : '0;
  assign rd_addr.y = visible ? Y_BITS'(v_cnt) : '0;

  // stage 1 matches the memory read
  // stage 2 is the output register
  always_ff @(posedge clk) begin
    if (rst) begin
      vis_d     <= 1'b0;
      hsync_d   <= 1'b1;
      vsync_d   <= 1'b1;
      vga_hsync <= 1'b1;
      vga_vsync <= 1'b1;
      vga_rgb   <= '0;
    end else begin
      vis_d     <= visible;
      hsync_d   <= hsync_n;
      vsync_d   <= vsync_n;
      vga_hsync <= hsync_d;
      vga_vsync <= vsync_d;
      // black outside the visible area
      vga_rgb   <= vis_d ? rgb_t'(rd_color) : '0;
    end
  end

endmodule

// File: hdl/adc_xy_vga.sv
`timescale 1ns/10ps
`include "scope_macros.svh"

module adc_xy_vga (
  input  logic                           clk,
  input  logic                           rst,
  input  logic [`ADC_BITS-1:0]           adc_x,
  input  logic [`ADC_BITS-1:0]           adc_y,
  input  logic                           adc_strobe,
  input  logic                           cfg_we,
  input  scope_pkg::reg_addr_e           cfg_addr,
  input  logic [scope_pkg::PIX_BITS-1:0] cfg_wdata,
  output scope_pkg::rgb_t                vga_rgb,
  output logic                           vga_hsync,
  output logic                           vga_vsync
);
  import scope_pkg::*;

  // register outputs
  logic [PIX_BITS-1:0] bg_color;
  logic [PIX_BITS-1:0] trace_color;

  // clear engine link
  logic      clr_start;
  logic      clr_take;
  logic      clr_avail;
  logic      clr_last;
  pixel_wr_t clr_pix;

  // trace link
  logic      trace_take;
  logic      trace_avail;
  pixel_wr_t trace_pix;

  // framebuffer write and read
  logic                wr_valid;
  pixel_wr_t           wr_pix;
  logic                credit_ret;
  fb_addr_t            rd_addr;
  logic [PIX_BITS-1:0] rd_color;

  fb_clear fb_clear_inst (
    .clk      (clk),
    .rst      (rst),
    .clr_start(clr_start),
    .clr_take (clr_take),
    .bg_color (bg_color),
    .clr_avail(clr_avail),
    .clr_pix  (clr_pix),
    .clr_last (clr_last)
  );

  adc_sampler adc_sampler_inst (
    .clk        (clk),
    .rst        (rst),
    .adc_x      (adc_x),
    .adc_y      (adc_y),
    .adc_strobe (adc_strobe),
    .trace_take (trace_take),
    .trace_color(trace_color),
    .trace_avail(trace_avail),
    .trace_pix  (trace_pix)
  );

  scope_ctrl scope_ctrl_inst (
    .clk        (clk),
    .rst        (rst),
    .cfg_we     (cfg_we),
    .cfg_addr   (cfg_addr),
    .cfg_wdata  (cfg_wdata),
    .clr_avail  (clr_avail),
    .clr_pix    (clr_pix),
    .clr_last   (clr_last),
    .trace_avail(trace_avail),
    .trace_pix  (trace_pix),
    .credit_ret (credit_ret),
    .bg_color   (bg_color),
    .trace_color(trace_color),
    .clr_start  (clr_start),
    .clr_take   (clr_take),
    .trace_take (trace_take),
    .wr_valid   (wr_valid),
    .wr_pix     (wr_pix)
  );

  frame_store frame_store_inst (
    .clk       (clk),
    .rst       (rst),
    .wr_valid  (wr_valid),
    .wr_pix    (wr_pix),
    .rd_addr   (rd_addr),
    .credit_ret(credit_ret),
    .rd_color  (rd_color)
  );

  vga_scan vga_scan_inst (
    .clk      (clk),
    .rst      (rst),
    .rd_color (rd_color),
    .rd_addr  (rd_addr),
    .vga_rgb  (vga_rgb),
    .vga_hsync(vga_hsync),
    .vga_vsync(vga_vsync)
  );

endmodule

// File: verification/tb_clk_gen.sv
`timescale 1ns/10ps

module tb_clk_gen #(
  parameter int PERIOD_NS = 8
) (
  output logic clk
);

  // free running, low for the first half period
  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

endmodule

// File: verification/adc_xy_vga_chk.sv
`timescale 1ns/10ps
`include "scope_macros.svh"

module adc_xy_vga_chk #(
  parameter bit SCAN_SIDE = 1'b0,
  parameter int CR_BITS = $clog2(`FB_CREDITS + 1)
) (
  input logic                 clk,
  input logic                 rst,
  input logic [CR_BITS-1:0]   credits,
  input logic                 wr_valid,
  input scope_pkg::seq_state_e state,
  input logic                 clr_take,
  input logic                 trace_take,
  input logic                 hsync
);
  import scope_pkg::*;

  generate
    if (!SCAN_SIDE) begin : g_ctrl
      // pool never grows past the queue depth
      a_credit_max: assert property (@(posedge clk) disable iff (rst)
        credits <= CR_BITS'(`FB_CREDITS))
        else $error("credit count above the write queue depth");

      // a write always spends a credit that exists
      a_credit_held: assert property (@(posedge clk) disable iff (rst)
        wr_valid |-> (credits != '0))
        else $error("framebuffer write with no credit held");

      // settle window forwards nothing
      a_settle_idle: assert property (@(posedge clk) disable iff (rst)
        (state == ST_SETTLE) |-> !(clr_take || trace_take))
        else $error("producer take during settle");
    end else begin : g_scan
      localparam int LOW_BITS = $clog2(`H_TOTAL + 1);

      logic [LOW_BITS-1:0] hs_low;

      // length of the current low run
      always_ff @(posedge clk) begin
        if (rst) begin
          hs_low <= '0;
        end else if (!hsync) begin
          hs_low <= hs_low + LOW_BITS'(1);
        end else begin
          hs_low <= '0;
        end
      end

      // checked on the rising edge that ends the pulse
      a_hsync_width: assert property (@(posedge clk) disable iff (rst)
        $rose(hsync) |-> (hs_low == LOW_BITS'(`H_SYNC)))
        else $error("hsync low time differs from H_SYNC");
    end
  endgenerate

endmodule

bind scope_ctrl adc_xy_vga_chk #(.SCAN_SIDE(1'b0)) u_ctrl_chk (
  .clk       (clk),
  .rst       (rst),
  .credits   (credits),
  .wr_valid  (wr_valid),
  .state     (state),
  .clr_take  (clr_take),
  .trace_take(trace_take),
  .hsync     (1'b1)
);

bind vga_scan adc_xy_vga_chk #(.SCAN_SIDE(1'b1)) u_scan_chk (
  .clk       (clk),
  .rst       (rst),
  .credits   ('0),
  .wr_valid  (1'b0),
  .state     (scope_pkg::ST_CLEAR),
  .clr_take  (1'b0),
  .trace_take(1'b0),
  .hsync     (vga_hsync)
);

// File: verification/adc_xy_vga_tb.sv
`timescale 1ns/10ps
`include "scope_macros.svh"

module adc_xy_vga_tb;
  import scope_pkg::*;

  localparam int W = `FB_WIDTH;
  localparam int H = `FB_HEIGHT;
  localparam int HT = `H_TOTAL;
  localparam int VT = `V_TOTAL;
  localparam int FRAME = HT * VT;
  localparam int ADC_W = `ADC_BITS;
  localparam int XB = $clog2(`FB_WIDTH);
  localparam int YB = $clog2(`FB_HEIGHT);
  localparam int AB = $clog2(`FB_WIDTH * `FB_HEIGHT);
  localparam int PIX = 3 * `COLOR_BITS;
  // vsync falls at line FB_HEIGHT + V_FRONT, pixel 0
  localparam int LEAD = (VT - (`FB_HEIGHT + `V_FRONT)) * HT;
  localparam int SYNC_LIMIT = 2 * FRAME + 10;
  localparam int CLEAR_LIMIT = 4 * W * H + 4 * `SETTLE_CYCLES + 50;
  // strobe, pending, take, plus slack
  localparam int POINT_GAP = 3;
  localparam int BURST = 6;

  // one table row, register write or ADC point
  typedef struct packed {
    logic             is_reg;
    reg_addr_e        addr;
    logic [PIX-1:0]   data;
    logic [ADC_W-1:0] ax;
    logic [ADC_W-1:0] ay;
    logic [XB-1:0]    ex;
    logic [YB-1:0]    ey;
    logic [PIX-1:0]   ecolor;
  } step_t;

  logic             clk;
  logic             rst;
  logic [ADC_W-1:0] adc_x;
  logic [ADC_W-1:0] adc_y;
  logic             adc_strobe;
  logic             cfg_we;
  reg_addr_e        cfg_addr;
  logic [PIX-1:0]   cfg_wdata;
  rgb_t             vga_rgb;
  logic             vga_hsync;
  logic             vga_vsync;

  step_t          steps[$];
  logic [PIX-1:0] frame_img [W*H];
  logic [PIX-1:0] ref_img [W*H];
  int             burst_x[$];
  int             burst_y[$];
  logic [PIX-1:0] model_bg;
  logic [PIX-1:0] model_trace;
  logic [PIX-1:0] restart_word;
  integer         seed;
  int             err_count;
  int             err_mark;
  int             tests_run;
  int             tests_failed;
  int             blank_bad;
  int             low_w;
  int             period;
  int             i;
  bit             timed_out;

  tb_clk_gen #(.PERIOD_NS(8)) u_clk (.clk(clk));

  adc_xy_vga u_dut (
    .clk       (clk),
    .rst       (rst),
    .adc_x     (adc_x),
    .adc_y     (adc_y),
    .adc_strobe(adc_strobe),
    .cfg_we    (cfg_we),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .vga_rgb   (vga_rgb),
    .vga_hsync (vga_hsync),
    .vga_vsync (vga_vsync)
  );

  // full ADC range spread over the frame
  function automatic logic [XB-1:0] scale_x(input logic [ADC_W-1:0] raw);
    return XB'(raw >> (ADC_W - XB));
  endfunction

  function automatic logic [YB-1:0] scale_y(input logic [ADC_W-1:0] raw);
    return YB'(raw >> (ADC_W - YB));
  endfunction

  // raster order word of a visible pixel
  function automatic logic [AB-1:0] pix_index(input int x, input int y);
    return AB'(y * W + x);
  endfunction

  task automatic report_timeout(input string what);
    $display("timeout: no %s within the cycle limit", what);
    timed_out = 1'b1;
  endtask

  task automatic push_reg(input reg_addr_e addr, input logic [PIX-1:0] data);
    step_t s;
    s = '0;
    s.is_reg = 1'b1;
    s.addr = addr;
    s.data = data;
    // trace colour applies to points strobed afterwards
    if (addr == REG_TRACE_COLOR) begin
      model_trace = data;
    end
    steps.push_back(s);
  endtask

  task automatic add_point(input logic [ADC_W-1:0] ax, input logic [ADC_W-1:0] ay);
    step_t s;
    s = '0;
    s.ax = ax;
    s.ay = ay;
    s.ex = scale_x(ax);
    s.ey = scale_y(ay);
    s.ecolor = model_trace;
    steps.push_back(s);
  endtask

  task automatic cfg_write(input reg_addr_e addr, input logic [PIX-1:0] data);
    cfg_we = 1'b1;
    cfg_addr = addr;
    cfg_wdata = data;
    @(negedge clk);
    cfg_we = 1'b0;
  endtask

  task automatic strobe_point(input logic [ADC_W-1:0] ax, input logic [ADC_W-1:0] ay);
    adc_x = ax;
    adc_y = ay;
    adc_strobe = 1'b1;
    @(negedge clk);
    adc_strobe = 1'b0;
    repeat (POINT_GAP) @(negedge clk);
  endtask

  task automatic wait_for_trace();
    int n;
    n = 0;
    while (u_dut.scope_ctrl_inst.state != ST_TRACE && n < CLEAR_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (u_dut.scope_ctrl_inst.state != ST_TRACE) begin
      report_timeout("end of the clear sweep");
    end
  endtask

  // shadow image of one frame, aligned on the vsync falling edge
  task automatic capture_frame();
    int  n;
    int  h;
    int  v;
    logic prev;
    bit  found;
    found = 1'b0;
    n = 0;
    prev = vga_vsync;
    while (!found && n < SYNC_LIMIT) begin
      @(negedge clk);
      n++;
      if (prev && !vga_vsync) begin
        found = 1'b1;
      end
      prev = vga_vsync;
    end
    if (!found) begin
      report_timeout("falling vsync before a frame capture");
      return;
    end
    blank_bad = 0;
    repeat (LEAD - 1) @(negedge clk);
    for (v = 0; v < VT; v++) begin
      for (h = 0; h < HT; h++) begin
        @(negedge clk);
        if (h < W && v < H) begin
          frame_img[pix_index(h, v)] = vga_rgb;
        end else if (vga_rgb != '0) begin
          blank_bad++;
        end
      end
    end
  endtask

  // low width and period, counted from one falling edge to the next
  task automatic count_sync(input bit vert, output int low_n, output int per_n);
    int   n;
    logic prev;
    logic cur;
    bit   found;
    bit   risen;
    low_n = 0;
    per_n = 0;
    found = 1'b0;
    n = 0;
    prev = vert ? vga_vsync : vga_hsync;
    while (!found && n < SYNC_LIMIT) begin
      @(negedge clk);
      n++;
      cur = vert ? vga_vsync : vga_hsync;
      if (prev && !cur) begin
        found = 1'b1;
      end
      prev = cur;
    end
    if (!found) begin
      report_timeout(vert ? "falling vsync" : "falling hsync");
      return;
    end
    low_n = 1;
    per_n = 1;
    risen = 1'b0;
    found = 1'b0;
    n = 0;
    while (!found && n < SYNC_LIMIT) begin
      @(negedge clk);
      n++;
      cur = vert ? vga_vsync : vga_hsync;
      if (!cur && risen) begin
        found = 1'b1;
      end else begin
        per_n++;
        if (!cur) begin
          low_n++;
        end else begin
          risen = 1'b1;
        end
      end
    end
    if (!found) begin
      report_timeout("second sync pulse");
    end
  endtask

  task automatic fill_ref(input logic [PIX-1:0] color);
    int x;
    int y;
    for (y = 0; y < H; y++) begin
      for (x = 0; x < W; x++) begin
        ref_img[pix_index(x, y)] = color;
      end
    end
  endtask

  task automatic compare_frame();
    int x;
    int y;
    for (y = 0; y < H; y++) begin
      for (x = 0; x < W; x++) begin
        if (frame_img[pix_index(x, y)] !== ref_img[pix_index(x, y)]) begin
          err_count++;
          $display("[FAIL] %0t ns: pixel (%0d,%0d) reads %03h, expected %03h", $time,
                   x, y, frame_img[pix_index(x, y)], ref_img[pix_index(x, y)]);
        end
      end
    end
  endtask

  // burst may only add its own points on top of the earlier image
  task automatic check_burst();
    int             x;
    int             y;
    int             k;
    bit             hit;
    logic [PIX-1:0] got;
    for (y = 0; y < H; y++) begin
      for (x = 0; x < W; x++) begin
        got = frame_img[pix_index(x, y)];
        hit = 1'b0;
        for (k = 0; k < burst_x.size(); k++) begin
          if (burst_x[k] == x && burst_y[k] == y) begin
            hit = 1'b1;
          end
        end
        if (got !== ref_img[pix_index(x, y)] && !(hit && got === model_trace)) begin
          err_count++;
          $display("[FAIL] %0t ns: pixel (%0d,%0d) reads %03h, neither image nor burst",
                   $time, x, y, got);
        end
      end
    end
    k = burst_x.size() - 1;
    got = frame_img[pix_index(burst_x[k], burst_y[k])];
    if (got !== model_trace) begin
      err_count++;
      $display("[FAIL] %0t ns: last burst point (%0d,%0d) reads %03h, expected %03h",
               $time, burst_x[k], burst_y[k], got, model_trace);
    end
  endtask

  task automatic end_test(input int num, input string name);
    tests_run++;
    if (timed_out || err_count != err_mark) begin
      tests_failed++;
      $display("test %0d %s: failed", num, name);
    end else begin
      $display("test %0d %s: ok", num, name);
    end
    err_mark = err_count;
  endtask

  // point table, expected values follow the scaling rule
  task automatic build_table();
    add_point(10'h000, 10'h000);
    add_point(10'h3ff, 10'h3ff);
    add_point(10'h200, 10'h100);
    add_point(10'h0c0, 10'h2ff);
    push_reg(REG_TRACE_COLOR, 12'h0f0);
    add_point(10'h150, 10'h3a0);
    add_point(10'h37f, 10'h040);
    push_reg(REG_TRACE_COLOR, 12'h00f);
    add_point(10'h1c5, 10'h1c5);
  endtask

  initial begin
    logic [ADC_W-1:0] bx;
    logic [ADC_W-1:0] by;
    seed = 28584;
    err_count = 0;
    err_mark = 0;
    tests_run = 0;
    tests_failed = 0;
    blank_bad = 0;
    timed_out = 1'b0;
    model_bg = '0;
    model_trace = '1;
    restart_word = '0;
    restart_word[CTRL_RESTART_BIT] = 1'b1;
    rst = 1'b1;
    adc_x = '0;
    adc_y = '0;
    adc_strobe = 1'b0;
    cfg_we = 1'b0;
    cfg_addr = REG_BG_COLOR;
    cfg_wdata = '0;
    repeat (5) @(negedge clk);

    // reset values on the video outputs
    if (vga_hsync !== 1'b1 || vga_vsync !== 1'b1 || vga_rgb !== '0) begin
      err_count++;
      $display("[FAIL] %0t ns: after reset hsync %b vsync %b rgb %03h, expected 1 1 000",
               $time, vga_hsync, vga_vsync, vga_rgb);
    end
    rst = 1'b0;
    wait_for_trace();
    if (!timed_out) begin
      capture_frame();
    end
    if (!timed_out) begin
      fill_ref(model_bg);
      compare_frame();
    end
    end_test(1, "reset clears to background");

    if (!timed_out) begin
      count_sync(1'b0, low_w, period);
      if (!timed_out && (low_w != `H_SYNC || period != HT)) begin
        err_count++;
        $display("[FAIL] %0t ns: hsync low %0d period %0d, expected %0d and %0d",
                 $time, low_w, period, `H_SYNC, HT);
      end
      if (!timed_out) begin
        count_sync(1'b1, low_w, period);
      end
      if (!timed_out && (low_w != `V_SYNC * HT || period != FRAME)) begin
        err_count++;
        $display("[FAIL] %0t ns: vsync low %0d period %0d, expected %0d and %0d",
                 $time, low_w, period, `V_SYNC * HT, FRAME);
      end
      end_test(2, "sync timing");
    end

    if (!timed_out) begin
      model_bg = 12'h124;
      cfg_write(REG_BG_COLOR, model_bg);
      cfg_write(REG_CTRL, restart_word);
      wait_for_trace();
      if (!timed_out) begin
        capture_frame();
      end
      if (!timed_out) begin
        fill_ref(model_bg);
        compare_frame();
        // parked read address now returns colour, so missing blanking shows
        if (blank_bad != 0) begin
          err_count++;
          $display("[FAIL] %0t ns: %0d blanking samples carry colour", $time, blank_bad);
        end
      end
      end_test(3, "new background and blanking");
    end

    if (!timed_out) begin
      build_table();
      for (i = 0; i < steps.size(); i++) begin
        if (steps[i].is_reg) begin
          cfg_write(steps[i].addr, steps[i].data);
        end else begin
          strobe_point(steps[i].ax, steps[i].ay);
        end
      end
      capture_frame();
      if (!timed_out) begin
        fill_ref(model_bg);
        for (i = 0; i < steps.size(); i++) begin
          if (!steps[i].is_reg) begin
            ref_img[pix_index(int'(steps[i].ex), int'(steps[i].ey))] = steps[i].ecolor;
          end
        end
        compare_frame();
      end
      end_test(4, "table points in trace colour");
    end

    if (!timed_out) begin
      // back to back strobes, one per cycle
      for (i = 0; i < BURST; i++) begin
        bx = ADC_W'($random(seed));
        by = ADC_W'($random(seed));
        burst_x.push_back(int'(scale_x(bx)));
        burst_y.push_back(int'(scale_y(by)));
        adc_x = bx;
        adc_y = by;
        adc_strobe = 1'b1;
        @(negedge clk);
      end
      adc_strobe = 1'b0;
      capture_frame();
      if (!timed_out) begin
        check_burst();
      end
      end_test(5, "strobe burst");
    end

    if (!timed_out) begin
      cfg_write(REG_CTRL, restart_word);
      // these land while the sweep runs
      for (i = 0; i < 3; i++) begin
        adc_x = ADC_W'($random(seed));
        adc_y = ADC_W'($random(seed));
        adc_strobe = 1'b1;
        @(negedge clk);
      end
      adc_strobe = 1'b0;
      wait_for_trace();
      if (!timed_out) begin
        capture_frame();
      end
      if (!timed_out) begin
        fill_ref(model_bg);
        compare_frame();
      end
      end_test(6, "restart erases trace");
    end

    $display("tests run %0d, failed %0d, check errors %0d", tests_run, tests_failed,
             err_count);
    if (timed_out || err_count != 0 || tests_failed != 0) begin
      $display("Simulation failed");
    end else begin
      $display("Simulation completed successfully");
    end
    $finish;
  end

endmodule

// File: adc_xy_scope.f
+incdir+hdl
hdl/scope_pkg.sv
hdl/fb_clear.sv
hdl/adc_sampler.sv
hdl/scope_ctrl.sv
hdl/frame_store.sv
hdl/vga_scan.sv
hdl/adc_xy_vga.sv
verification/tb_clk_gen.sv
verification/adc_xy_vga_chk.sv
verification/adc_xy_vga_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --assert \
  --top-module adc_xy_vga_tb \
  -f adc_xy_scope.f \
  -o adc_xy_vga_sim

sim_out="$(./obj_dir/adc_xy_vga_sim 2>&1)"
echo "$sim_out"

if grep -q "Simulation completed successfully" <<< "$sim_out"; then
  exit 0
else
  exit 1
fi
